/* common/fe_consts.svh */
/*
 * Fetch frontend constants.
 * Address and instruction widths, table depths and the reset fetch address.
 */

`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// ------------------------------
// widths
// ------------------------------
`define FE_VLEN 32
`define FE_ILEN 32

// first fetch after reset
`define FE_BOOT_ADDR 32'h8000_0000

// ------------------------------
// predictor and queue sizes
// ------------------------------
// one counter per word address, indexed from pc bit 2
`define FE_BHT_ENTRIES 16
`define FE_RAS_DEPTH 2
// power of two, the queue pointers wrap naturally
`define FE_QUEUE_DEPTH 4

`endif

/* common/fe_pkg.sv */
/*
 * Fetch frontend types.
 * Control-flow kinds, major opcodes and the structs passed between blocks.
 */

`include "fe_consts.svh"

package fe_pkg;

    // control-flow class of a fetched instruction
    typedef enum logic [2:0] {
        NO_CF,
        BRANCH,
        JUMP,
        JUMPR,
        RETURN
    } cf_e;

    // major opcodes seen by the predecoder, real RV32I encodings
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        // op-imm stands for everything that is not control flow
        OP_OTHER  = 7'b0010011
    } opcode_e;

    // ------------------------------
    // memory port
    // ------------------------------
    typedef struct packed {
        logic               req;
        logic [`FE_VLEN-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic               valid;
        logic [`FE_ILEN-1:0] data;
    } fetch_rsp_t;

    // branch outcome from the back end
    typedef struct packed {
        logic               valid;
        logic [`FE_VLEN-1:0] pc;
        logic [`FE_VLEN-1:0] target;
        logic               is_taken;
        logic               is_mispredict;
        cf_e                cf;
    } bp_resolve_t;

    // ------------------------------
    // predictors
    // ------------------------------
    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

    typedef struct packed {
        logic               valid;
        logic [`FE_VLEN-1:0] pc;
        logic               taken;
    } bht_update_t;

    typedef struct packed {
        logic               valid;
        logic [`FE_VLEN-1:0] ra;
    } ras_entry_t;

    // one instruction toward the back end
    typedef struct packed {
        logic [`FE_VLEN-1:0] pc;
        logic [`FE_ILEN-1:0] instr;
        cf_e                cf;
        logic               predict_taken;
        logic [`FE_VLEN-1:0] predict_target;
    } fetch_entry_t;

endpackage

/* hdl/bht.sv */
/*
 * Branch history table.
 * One 2-bit saturating counter per word address, trained by resolved branches.
 */

`include "fe_consts.svh"

module bht #(
    parameter int unsigned NR_ENTRIES = `FE_BHT_ENTRIES
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic [`FE_VLEN-1:0] pc_i,
    input  fe_pkg::bht_update_t update_i,
    output fe_pkg::bht_pred_t   prediction_o
);

    localparam int unsigned IDX_W = $clog2(NR_ENTRIES);

    logic [NR_ENTRIES-1:0]      valid_q;
    logic [NR_ENTRIES-1:0][1:0] cnt_q;
    logic [IDX_W-1:0]           rd_idx;
    logic [IDX_W-1:0]           wr_idx;
    logic [1:0]                 cnt_base;
    logic [1:0]                 cnt_next;

    // word index, pc bits from bit 2 upward
    assign rd_idx = pc_i[IDX_W+1:2];
    assign wr_idx = update_i.pc[IDX_W+1:2];

    // taken from weakly taken upward
    assign prediction_o.valid = valid_q[rd_idx];
    assign prediction_o.taken = cnt_q[rd_idx][1];

    // a fresh entry counts from weakly not taken
    always_comb begin
        cnt_base = valid_q[wr_idx] ? cnt_q[wr_idx] : 2'd1;
        cnt_next = cnt_base;
        if (update_i.taken && cnt_base != 2'd3) begin
            cnt_next = cnt_base + 2'd1;
        end else if (!update_i.taken && cnt_base != 2'd0) begin
            cnt_next = cnt_base - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid) begin
            cnt_q[wr_idx] <= cnt_next;
        end
    end

endmodule

/* hdl/ras.sv */
/*
 * Return address stack.
 * Shift stack, entry 0 is the top; the oldest entry falls off on overflow.
 */

`include "fe_consts.svh"

module ras #(
    parameter int unsigned DEPTH = `FE_RAS_DEPTH
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                push_i,
    input  logic                pop_i,
    input  logic [`FE_VLEN-1:0] data_i,
    output fe_pkg::ras_entry_t  top_o
);

    fe_pkg::ras_entry_t [DEPTH-1:0] stack_q;

    assign top_o = stack_q[0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stack_q <= '0;
        end else if (flush_i) begin
            stack_q <= '0;
        end else if (push_i) begin
            // shift down, bottom entry is lost when full
            stack_q[0].valid <= 1'b1;
            stack_q[0].ra    <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stack_q[i] <= stack_q[i-1];
            end
        end else if (pop_i) begin
            // shift up, an empty slot enters at the bottom
            for (int i = 0; i < DEPTH - 1; i++) begin
                stack_q[i] <= stack_q[i+1];
            end
            stack_q[DEPTH-1] <= '0;
        end
    end

    // a single instruction is either a call or a return, never both
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && pop_i));

endmodule

/* frontend/pc_gen.sv */
/*
 * Next-PC generation.
 * Issues one fetch at a time, drops stale responses and applies
 * the redirect priority commit, exception, eret, mispredict, prediction.
 */

`include "fe_consts.svh"

module pc_gen (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                fetch_rsp_valid_i,
    input  logic                predict_taken_i,
    input  logic [`FE_VLEN-1:0] predict_target_i,
    input  fe_pkg::bp_resolve_t resolved_branch_i,
    input  logic                eret_i,
    input  logic [`FE_VLEN-1:0] epc_i,
    input  logic                ex_valid_i,
    input  logic [`FE_VLEN-1:0] trap_vector_base_i,
    input  logic                set_pc_commit_i,
    input  logic [`FE_VLEN-1:0] pc_commit_i,
    input  logic                queue_full_i,
    output fe_pkg::fetch_req_t  fetch_req_o,
    output logic [`FE_VLEN-1:0] fetch_pc_o,
    output logic                accept_o,
    output logic                redirect_o
);

    localparam logic [`FE_VLEN-1:0] INSTR_BYTES = 4;

    logic [`FE_VLEN-1:0] npc_d, npc_q;
    logic [`FE_VLEN-1:0] inflight_pc_q;
    logic                started_q;
    logic                outstanding_q;
    logic                stale_q;
    logic                mispredict;
    logic                req;

    assign mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;
    assign redirect_o = set_pc_commit_i | ex_valid_i | eret_i | mispredict;

    // first request one cycle after reset, then only with a free queue slot
    assign req              = started_q & ~outstanding_q & ~queue_full_i;
    assign fetch_req_o.req  = req;
    assign fetch_req_o.addr = npc_q;
    assign fetch_pc_o       = inflight_pc_q;

    // a redirect now or in the request cycle makes the response stale
    assign accept_o = fetch_rsp_valid_i & outstanding_q & ~stale_q & ~redirect_o;

    // ------------------------------
    // next pc by redirect priority
    // ------------------------------
    always_comb begin
        npc_d = npc_q;
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + INSTR_BYTES;
        end else if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end else if (eret_i) begin
            npc_d = epc_i;
        end else if (mispredict) begin
            npc_d = resolved_branch_i.target;
        end else if (accept_o && predict_taken_i) begin
            npc_d = predict_target_i;
        end else if (accept_o) begin
            npc_d = inflight_pc_q + INSTR_BYTES;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q         <= `FE_BOOT_ADDR;
            started_q     <= 1'b0;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
        end else begin
            started_q <= 1'b1;
            npc_q     <= npc_d;
            if (req) begin
                outstanding_q <= 1'b1;
                stale_q       <= redirect_o;
            end else if (outstanding_q) begin
                // memory answers in exactly the next cycle
                outstanding_q <= 1'b0;
                stale_q       <= 1'b0;
            end
        end
    end

    // address of the word in flight
    always_ff @(posedge clk_i) begin
        if (req) begin
            inflight_pc_q <= npc_q;
        end
    end

    // memory answers in exactly the cycle after each request and never otherwise
    assert property (@(posedge clk_i) disable iff (!rst_ni) fetch_rsp_valid_i == outstanding_q);

endmodule

/* frontend/predecode.sv */
/*
 * Predecoder.
 * Classifies the fetched word and predicts its direction and target
 * from the immediate, the BHT and the RAS.
 */

`include "fe_consts.svh"

module predecode (
    input  logic                 accept_i,
    input  logic [`FE_VLEN-1:0]  pc_i,
    input  logic [`FE_ILEN-1:0]  instr_i,
    input  fe_pkg::bht_pred_t    bht_i,
    input  fe_pkg::ras_entry_t   ras_i,
    output fe_pkg::fetch_entry_t entry_o,
    output logic                 ras_push_o,
    output logic                 ras_pop_o,
    output logic [`FE_VLEN-1:0]  ras_data_o
);

    fe_pkg::opcode_e     opcode;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic                rd_link;
    logic                rs1_link;
    logic [`FE_VLEN-1:0] imm_j;
    logic [`FE_VLEN-1:0] imm_b;
    logic [`FE_VLEN-1:0] pc_seq;

    assign rd  = instr_i[11:7];
    assign rs1 = instr_i[19:15];
    // x1 and x5 are the link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // sign-extended jump and branch offsets
    assign imm_j = {{(`FE_VLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_b = {{(`FE_VLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    assign pc_seq     = pc_i + `FE_VLEN'(4);
    // calls always link to the next word
    assign ras_data_o = pc_seq;

    always_comb begin
        case (instr_i[6:0])
            fe_pkg::OP_BRANCH: opcode = fe_pkg::OP_BRANCH;
            fe_pkg::OP_JAL:    opcode = fe_pkg::OP_JAL;
            fe_pkg::OP_JALR:   opcode = fe_pkg::OP_JALR;
            default:           opcode = fe_pkg::OP_OTHER;
        endcase
    end

    // ------------------------------
    // classification and prediction
    // ------------------------------
    always_comb begin
        entry_o.pc             = pc_i;
        entry_o.instr          = instr_i;
        entry_o.cf             = fe_pkg::NO_CF;
        entry_o.predict_taken  = 1'b0;
        entry_o.predict_target = pc_seq;
        ras_push_o             = 1'b0;
        ras_pop_o              = 1'b0;
        case (opcode)
            fe_pkg::OP_JAL: begin
                entry_o.cf             = fe_pkg::JUMP;
                entry_o.predict_taken  = 1'b1;
                entry_o.predict_target = pc_i + imm_j;
                ras_push_o             = accept_i & rd_link;
            end
            fe_pkg::OP_JALR: begin
                if (rd == 5'd0 && rs1_link) begin
                    // return, only predicted while the stack holds an address
                    entry_o.cf            = fe_pkg::RETURN;
                    entry_o.predict_taken = ras_i.valid;
                    if (ras_i.valid) begin
                        entry_o.predict_target = ras_i.ra;
                    end
                    ras_pop_o = accept_i & ras_i.valid;
                end else begin
                    // no BTB, register jumps fall through
                    entry_o.cf = fe_pkg::JUMPR;
                    ras_push_o = accept_i & rd_link;
                end
            end
            fe_pkg::OP_BRANCH: begin
                entry_o.cf = fe_pkg::BRANCH;
                // cold entry: backward taken, forward not taken
                entry_o.predict_taken  = bht_i.valid ? bht_i.taken : imm_b[`FE_VLEN-1];
                entry_o.predict_target = pc_i + imm_b;
            end
            default: begin
                entry_o.cf = fe_pkg::NO_CF;
            end
        endcase
    end

endmodule

/* frontend/fetch_queue.sv */
/*
 * Fetch queue.
 * Circular FIFO of predecoded entries with a valid/ready output.
 */

`include "fe_consts.svh"

module fetch_queue #(
    parameter int unsigned DEPTH = `FE_QUEUE_DEPTH
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  fe_pkg::fetch_entry_t entry_i,
    output logic                 full_o,
    output fe_pkg::fetch_entry_t entry_o,
    output logic                 valid_o,
    input  logic                 ready_i
);

    localparam int unsigned PTR_W = $clog2(DEPTH);

    fe_pkg::fetch_entry_t mem_q [DEPTH];
    logic [PTR_W-1:0]     wptr_q;
    logic [PTR_W-1:0]     rptr_q;
    logic [PTR_W:0]       count_q;
    logic                 pop;

    assign valid_o = (count_q != '0);
    assign full_o  = (count_q == (PTR_W+1)'(DEPTH));
    assign entry_o = mem_q[rptr_q];
    assign pop     = valid_o & ready_i;

    // ------------------------------
    // pointers and fill level
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // redirect drops everything fetched so far
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wptr_q] <= entry_i;
        end
    end

    // pc_gen only fetches with a free slot
    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);

endmodule

/* frontend/frontend_top.sv */
/*
 * Fetch frontend top level.
 * Connects next-PC generation, predecode, BHT, RAS and the fetch queue.
 */

`include "fe_consts.svh"

module frontend_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // back end resolution strobe
    input  fe_pkg::bp_resolve_t  resolved_branch_i,
    // redirect sources
    input  logic                 eret_i,
    input  logic [`FE_VLEN-1:0]  epc_i,
    input  logic                 ex_valid_i,
    input  logic [`FE_VLEN-1:0]  trap_vector_base_i,
    input  logic                 set_pc_commit_i,
    input  logic [`FE_VLEN-1:0]  pc_commit_i,
    input  logic                 flush_bp_i,
    // instruction memory
    output fe_pkg::fetch_req_t   fetch_req_o,
    input  fe_pkg::fetch_rsp_t   fetch_rsp_i,
    // toward the back end
    output fe_pkg::fetch_entry_t fetch_entry_o,
    output logic                 fetch_entry_valid_o,
    input  logic                 fetch_entry_ready_i
);

    logic [`FE_VLEN-1:0]  fetch_pc;
    logic [`FE_VLEN-1:0]  ras_data;
    logic                 accept;
    logic                 redirect;
    logic                 queue_full;
    logic                 ras_push;
    logic                 ras_pop;
    fe_pkg::fetch_entry_t entry;
    fe_pkg::bht_pred_t    bht_pred;
    fe_pkg::bht_update_t  bht_update;
    fe_pkg::ras_entry_t   ras_top;

    // only conditional branches train the counters
    assign bht_update.valid = resolved_branch_i.valid & (resolved_branch_i.cf == fe_pkg::BRANCH);
    assign bht_update.pc    = resolved_branch_i.pc;
    assign bht_update.taken = resolved_branch_i.is_taken;

    pc_gen i_pc_gen (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .fetch_rsp_valid_i  (fetch_rsp_i.valid),
        .predict_taken_i    (entry.predict_taken),
        .predict_target_i   (entry.predict_target),
        .resolved_branch_i  (resolved_branch_i),
        .eret_i             (eret_i),
        .epc_i              (epc_i),
        .ex_valid_i         (ex_valid_i),
        .trap_vector_base_i (trap_vector_base_i),
        .set_pc_commit_i    (set_pc_commit_i),
        .pc_commit_i        (pc_commit_i),
        .queue_full_i       (queue_full),
        .fetch_req_o        (fetch_req_o),
        .fetch_pc_o         (fetch_pc),
        .accept_o           (accept),
        .redirect_o         (redirect)
    );

    predecode i_predecode (
        .accept_i   (accept),
        .pc_i       (fetch_pc),
        .instr_i    (fetch_rsp_i.data),
        .bht_i      (bht_pred),
        .ras_i      (ras_top),
        .entry_o    (entry),
        .ras_push_o (ras_push),
        .ras_pop_o  (ras_pop),
        .ras_data_o (ras_data)
    );

    bht #(
        .NR_ENTRIES (`FE_BHT_ENTRIES)
    ) i_bht (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_bp_i),
        .pc_i         (fetch_pc),
        .update_i     (bht_update),
        .prediction_o (bht_pred)
    );

    // stack is dropped on every redirect so wrong-path calls leave no trace
    ras #(
        .DEPTH (`FE_RAS_DEPTH)
    ) i_ras (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_bp_i | redirect),
        .push_i  (ras_push),
        .pop_i   (ras_pop),
        .data_i  (ras_data),
        .top_o   (ras_top)
    );

    fetch_queue #(
        .DEPTH (`FE_QUEUE_DEPTH)
    ) i_fetch_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (redirect),
        .push_i  (accept),
        .entry_i (entry),
        .full_o  (queue_full),
        .entry_o (fetch_entry_o),
        .valid_o (fetch_entry_valid_o),
        .ready_i (fetch_entry_ready_i)
    );

endmodule

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock and reset.
 * Free-running clock, active-low reset held for a few cycles.
 */

module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release just after an edge, like every other input
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rst_no = 1'b1;
    end

endmodule

/* sim/tb_frontend.sv */
/*
 * Fetch frontend testbench.
 * Random program and redirects from a fixed LFSR seed; every entry that leaves
 * the queue is checked against a reference model of next pc, BHT and RAS.
 */

`include "fe_consts.svh"

module tb_frontend;

    localparam int NUM_ENTRIES = 1500;
    localparam int IDLE_LIMIT  = 200;
    localparam int RESET_LIMIT = 50;
    localparam int PROG_WORDS  = 64;
    localparam int BHT_IDX_W   = $clog2(`FE_BHT_ENTRIES);
    localparam int DRIVE_DELAY = 2;
    // kinds of program words
    localparam int K_PLAIN     = 0;
    localparam int K_BRANCH    = 1;
    localparam int K_JAL       = 2;
    localparam int K_CALL      = 3;
    localparam int K_RET       = 4;
    localparam int K_JALR      = 5;
    localparam int K_JALR_CALL = 6;

    logic                 clk;
    logic                 rst_n;
    fe_pkg::bp_resolve_t  resolved_branch;
    logic                 eret;
    logic [`FE_VLEN-1:0]  epc;
    logic                 ex_valid;
    logic [`FE_VLEN-1:0]  trap_vector_base;
    logic                 set_pc_commit;
    logic [`FE_VLEN-1:0]  pc_commit;
    logic                 flush_bp;
    fe_pkg::fetch_req_t   fetch_req;
    fe_pkg::fetch_rsp_t   fetch_rsp;
    fe_pkg::fetch_entry_t fetch_entry;
    logic                 fetch_entry_valid;
    logic                 fetch_entry_ready;

    // program memory and what each word was generated as
    logic [`FE_ILEN-1:0]  prog_mem [PROG_WORDS];
    logic [`FE_VLEN-1:0]  off_mem [PROG_WORDS];
    int                   kind_mem [PROG_WORDS];

    // reference model state
    logic [`FE_VLEN-1:0]        exp_pc;
    logic [`FE_BHT_ENTRIES-1:0] bht_v;
    logic [1:0]                 bht_c [`FE_BHT_ENTRIES];
    logic [`FE_RAS_DEPTH-1:0]   ras_v;
    logic [`FE_VLEN-1:0]        ras_a [`FE_RAS_DEPTH];
    logic [31:0]                lfsr;

    tb_clk_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (5)
    ) i_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    frontend_top DUT (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .resolved_branch_i   (resolved_branch),
        .eret_i              (eret),
        .epc_i               (epc),
        .ex_valid_i          (ex_valid),
        .trap_vector_base_i  (trap_vector_base),
        .set_pc_commit_i     (set_pc_commit),
        .pc_commit_i         (pc_commit),
        .flush_bp_i          (flush_bp),
        .fetch_req_o         (fetch_req),
        .fetch_rsp_i         (fetch_rsp),
        .fetch_entry_o       (fetch_entry),
        .fetch_entry_valid_o (fetch_entry_valid),
        .fetch_entry_ready_i (fetch_entry_ready)
    );

    // ------------------------------
    // random numbers
    // ------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[31]};
            lfsr = lfsr_step(lfsr);
        end
        return val;
    endfunction

    // word address inside the program window
    function automatic logic [`FE_VLEN-1:0] rand_addr();
        return `FE_BOOT_ADDR + (take_bits(6) << 2);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    // mostly plain words plus branches, jumps, calls and returns
    task automatic fill_program();
        logic [31:0] r;
        logic [31:0] off;
        logic [4:0]  link;
        logic [3:0]  sel;
        for (int i = 0; i < PROG_WORDS; i++) begin
            sel  = 4'(take_bits(4));
            r    = take_bits(6);
            // signed offset of -32 to +31 words
            off  = {{24{r[5]}}, r[5:0], 2'b00};
            link = take_bits(1) ? 5'd5 : 5'd1;
            r    = take_bits(25);
            off_mem[i] = off;
            case (sel)
                4'd9, 4'd10: begin
                    kind_mem[i] = K_BRANCH;
                    prog_mem[i] = {off[12], off[10:5], 5'd2, 5'd3, 3'b000, off[4:1], off[11],
                                   7'b1100011};
                end
                4'd11, 4'd12: begin
                    kind_mem[i] = (sel == 4'd12) ? K_CALL : K_JAL;
                    prog_mem[i] = {off[20], off[10:1], off[11], off[19:12],
                                   (sel == 4'd12) ? link : 5'd0, 7'b1101111};
                end
                4'd13: begin
                    kind_mem[i] = K_RET;
                    prog_mem[i] = {12'd0, link, 3'b000, 5'd0, 7'b1100111};
                end
                4'd14, 4'd15: begin
                    // rs1 x6 is never a link register
                    kind_mem[i] = (sel == 4'd15) ? K_JALR_CALL : K_JALR;
                    prog_mem[i] = {12'd0, 5'd6, 3'b000, (sel == 4'd15) ? link : 5'd0,
                                   7'b1100111};
                end
                default: begin
                    kind_mem[i] = K_PLAIN;
                    prog_mem[i] = {r[24:0], 7'b0010011};
                end
            endcase
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    task automatic check_entry(input int n);
        logic [`FE_VLEN-1:0]  pc;
        logic [`FE_VLEN-1:0]  off;
        logic [`FE_VLEN-1:0]  tgt;
        logic [BHT_IDX_W-1:0] bi;
        logic [2:0]           cf;
        logic                 taken;
        int                   k;
        pc    = exp_pc;
        k     = kind_mem[pc[7:2]];
        off   = off_mem[pc[7:2]];
        bi    = pc[BHT_IDX_W+1:2];
        cf    = fe_pkg::NO_CF;
        taken = 1'b0;
        tgt   = pc + 4;
        case (k)
            K_BRANCH: begin
                // cold counter falls back to backward taken
                cf    = fe_pkg::BRANCH;
                taken = bht_v[bi] ? bht_c[bi][1] : off[31];
                tgt   = pc + off;
            end
            K_JAL, K_CALL: begin
                cf    = fe_pkg::JUMP;
                taken = 1'b1;
                tgt   = pc + off;
            end
            K_RET: begin
                cf    = fe_pkg::RETURN;
                taken = ras_v[0];
                if (ras_v[0]) begin
                    tgt = ras_a[0];
                end
            end
            K_JALR, K_JALR_CALL: cf = fe_pkg::JUMPR;
            default: cf = fe_pkg::NO_CF;
        endcase
        check_eq($sformatf("entry %0d pc", n), pc, fetch_entry.pc);
        check_eq($sformatf("entry %0d instr", n), prog_mem[pc[7:2]], fetch_entry.instr);
        check_eq($sformatf("entry %0d cf", n), 32'(cf), 32'(fetch_entry.cf));
        check_eq($sformatf("entry %0d taken", n), 32'(taken), 32'(fetch_entry.predict_taken));
        check_eq($sformatf("entry %0d target", n), tgt, fetch_entry.predict_target);
        if (k == K_CALL || k == K_JALR_CALL) begin
            for (int i = `FE_RAS_DEPTH - 1; i > 0; i--) begin
                ras_v[i] = ras_v[i-1];
                ras_a[i] = ras_a[i-1];
            end
            ras_v[0] = 1'b1;
            ras_a[0] = pc + 4;
        end else if (k == K_RET && ras_v[0]) begin
            for (int i = 0; i < `FE_RAS_DEPTH - 1; i++) begin
                ras_v[i] = ras_v[i+1];
                ras_a[i] = ras_a[i+1];
            end
            ras_v[`FE_RAS_DEPTH-1] = 1'b0;
        end
        exp_pc = taken ? tgt : pc + 4;
    endtask

    // counters train first, then the stack drops and the pc jumps
    task automatic model_redirect();
        logic [1:0]           c;
        logic [BHT_IDX_W-1:0] bi;
        bi = resolved_branch.pc[BHT_IDX_W+1:2];
        if (flush_bp) begin
            bht_v = '0;
        end else if (resolved_branch.valid && resolved_branch.cf == fe_pkg::BRANCH) begin
            c = bht_v[bi] ? bht_c[bi] : 2'd1;
            if (resolved_branch.is_taken && c != 2'd3) begin
                c = c + 2'd1;
            end else if (!resolved_branch.is_taken && c != 2'd0) begin
                c = c - 2'd1;
            end
            bht_c[bi] = c;
            bht_v[bi] = 1'b1;
        end
        ras_v = '0;
        if (set_pc_commit) begin
            exp_pc = pc_commit + 4;
        end else if (ex_valid) begin
            exp_pc = trap_vector_base;
        end else if (eret) begin
            exp_pc = epc;
        end else begin
            exp_pc = resolved_branch.target;
        end
    endtask

    // rare redirects that may mix several sources in one cycle
    task automatic drive_redirect(input logic allow);
        logic [3:0] pick;
        set_pc_commit   = 1'b0;
        ex_valid        = 1'b0;
        eret            = 1'b0;
        flush_bp        = 1'b0;
        resolved_branch = '0;
        if (allow && take_bits(5) == 0) begin
            pick = 4'(take_bits(4));
            if (pick == 4'd0) begin
                pick = 4'b1000;
            end
            set_pc_commit                 = pick[0];
            ex_valid                      = pick[1];
            eret                          = pick[2];
            pc_commit                     = rand_addr();
            trap_vector_base              = rand_addr();
            epc                           = rand_addr();
            resolved_branch.valid         = pick[3];
            resolved_branch.is_mispredict = pick[3];
            resolved_branch.pc            = rand_addr();
            resolved_branch.target        = rand_addr();
            resolved_branch.is_taken      = take_bits(1);
            resolved_branch.cf            = take_bits(1) ? fe_pkg::BRANCH : fe_pkg::JUMPR;
            flush_bp                      = (take_bits(2) == 0);
        end
    endtask

    // ------------------------------
    // stimulus and memory
    // ------------------------------
    initial begin : stimulus
        logic                rsp_pending;
        logic [`FE_VLEN-1:0] rsp_addr;
        int                  n_xfer;
        int                  idle;
        int                  wait_cycles;
        lfsr              = 32'h9b4f0149;
        resolved_branch   = '0;
        eret              = 1'b0;
        epc               = '0;
        ex_valid          = 1'b0;
        trap_vector_base  = '0;
        set_pc_commit     = 1'b0;
        pc_commit         = '0;
        flush_bp          = 1'b0;
        fetch_rsp         = '0;
        fetch_entry_ready = 1'b0;
        exp_pc            = `FE_BOOT_ADDR;
        bht_v             = '0;
        ras_v             = '0;
        rsp_pending       = 1'b0;
        rsp_addr          = '0;
        n_xfer            = 0;
        idle              = 0;
        wait_cycles       = 0;
        fill_program();
        while (!rst_n) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_LIMIT) begin
                fail_run("timeout: reset was never released");
            end
        end
        while (n_xfer < NUM_ENTRIES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            // memory answers exactly one cycle after the request
            fetch_rsp.valid   = rsp_pending;
            fetch_rsp.data    = rsp_pending ? prog_mem[rsp_addr[7:2]] : '0;
            fetch_entry_ready = (take_bits(2) != 0);
            drive_redirect(n_xfer >= 8);
            @(negedge clk);
            if (fetch_entry_valid && fetch_entry_ready) begin
                check_entry(n_xfer);
                n_xfer++;
                idle = 0;
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) begin
                    fail_run("timeout: no fetch entry reached the back end");
                end
            end
            // a transfer in the same cycle still counts before the flush
            if (set_pc_commit || ex_valid || eret || resolved_branch.valid) begin
                model_redirect();
            end
            rsp_pending = fetch_req.req;
            rsp_addr    = fetch_req.addr;
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/fe_pkg.sv
hdl/bht.sv
hdl/ras.sv
frontend/pc_gen.sv
frontend/predecode.sv
frontend/fetch_queue.sv
frontend/frontend_top.sv
sim/tb_clk_gen.sv
sim/tb_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

export_include_dirs:
  - common

sources:
  - common/fe_pkg.sv
  - hdl/bht.sv
  - hdl/ras.sv
  - frontend/pc_gen.sv
  - frontend/predecode.sv
  - frontend/fetch_queue.sv
  - frontend/frontend_top.sv
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_frontend.sv
